/* files.f */
verilog/dlxPkg.sv
verilog/instrApbPort.sv
verilog/instrQueue.sv
verilog/control.sv
verilog/decodeStage.sv
verilog/dlxDecodeTop.sv
dv/tbClock.sv
dv/dlxDecodeProperties.sv
dv/dlxDecodeTb.sv

/* run.sh */
#!/bin/bash
# build and run with Verilator, result taken from the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module dlxDecodeTb \
    -f files.f -Mdir obj_dir -o simv > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/simv > sim.log 2>&1

grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; } \
    || grep -q "Simulation completed successfully" sim.log \
    || { echo "FAIL, run ended early"; exit 1; }
echo "PASS"

/* dv/dlxDecodeTb.sv */
module dlxDecodeTb
    import dlxPkg::*;
;

    localparam int QueueDepth = 4;
    localparam int Limit      = 200;

    logic clk, rstN, psel, penable, pwrite, ctrlReady;
    logic [7:0] paddr;
    instrT pwdata;
    logic [31:0] prdata;
    logic pready, pslverr, ctrlValid;
    instrT ctrlInstr;
    logic PCtoReg, regToPC, jump, branch, branchZero, RType, RegWrite;
    logic MemToReg, MemWrite, mul, extOp, LHIOp;
    logic [0:1] DSize;
    logic [0:3] ALUCtrl;

    // stimulus table, one entry per instruction
    string       rowName[$];
    instrT       rowInstr[$];
    logic [11:0] rowFlags[$];  // P R J B Z T W M S U E L
    logic [1:0]  rowDSize[$];
    logic [3:0]  rowAlu[$];
    int          expQ[$];      // table indices still owed by the DUT

    int          readyMode;    // 0 low, 1 high, 2 lfsr
    logic [31:0] lfsrState = 32'he7bd_57b0;

    tbClock #(.Period(20)) clkGen (.clk(clk));

    dlxDecodeTop #(.QueueDepth(QueueDepth)) uut (.*);

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act)
        else stopRun($sformatf("FAILED %s expected %0h actual %0h", name, exp, act));
    endtask

    // taps 32 22 2 1
    function automatic logic lfsrBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    task automatic addRow(input string name, input opcodeT op, input logic [25:0] rest,
                          input logic [11:0] flags, input logic [1:0] ds,
                          input logic [3:0] alu);
        rowName.push_back(name);
        rowInstr.push_back({op, rest});
        rowFlags.push_back(flags);
        rowDSize.push_back(ds);
        rowAlu.push_back(alu);
    endtask

    task automatic apbXfer(input logic wr, input logic [7:0] addr, input instrT data,
                           output logic [31:0] rdata, output logic err, output int waits);
        int cnt;
        cnt = 0;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        while (!pready) begin  // wait states
            cnt++;
            if (cnt > Limit) stopRun("APB transfer never completed");
            @(posedge clk);
        end
        waits = cnt;
        rdata = prdata;
        err = pslverr;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic writeRow(input int idx, output int waits);
        logic [31:0] rd;
        logic err;
        apbXfer(1'b1, instrAddr, rowInstr[idx], rd, err, waits);
        checkVal({rowName[idx], " pslverr"}, 0, err);
        expQ.push_back(idx);
    endtask

    task automatic readStatus(output logic [31:0] st);
        logic err;
        int waits;
        apbXfer(1'b0, statusAddr, '0, st, err, waits);
        checkVal("status pslverr", 0, err);
        checkVal("status waits", 0, waits);
    endtask

    task automatic waitDrain();
        int cnt;
        cnt = 0;
        while (expQ.size() > 0) begin
            cnt++;
            if (cnt > Limit) stopRun("output words missing after timeout");
            @(negedge clk);
        end
    endtask

    always @(negedge clk) begin
        case (readyMode)
            1: ctrlReady <= 1'b1;
            2: ctrlReady <= lfsrBit();
            default: ctrlReady <= 1'b0;
        endcase
    end

    // collector, compares each accepted word with the next owed row
    always @(posedge clk) begin
        int idx;
        if (rstN && ctrlValid && ctrlReady) begin
            if (expQ.size() == 0) stopRun("output word appeared with none expected");
            idx = expQ.pop_front();
            checkVal({rowName[idx], " instr"}, rowInstr[idx], ctrlInstr);
            checkVal({rowName[idx], " flags"}, rowFlags[idx],
                     {PCtoReg, regToPC, jump, branch, branchZero, RType, RegWrite,
                      MemToReg, MemWrite, mul, extOp, LHIOp});
            checkVal({rowName[idx], " DSize"}, rowDSize[idx], DSize);
            checkVal({rowName[idx], " ALUCtrl"}, rowAlu[idx], ALUCtrl);
        end
    end

    initial begin
        logic [31:0] st;
        logic err;
        int waits;
        rstN = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        ctrlReady = 1'b0;
        readyMode = 0;

        addRow("sub", opRType, {5'd1, 5'd2, 5'd3, 5'd0, 6'h22}, 12'b000001100000, 2'b00, 4'h2);
        addRow("rtype2c", opRType, {5'd4, 5'd5, 5'd6, 5'd0, 6'h2c}, 12'b000001100000,
               2'b00, 4'hc);
        addRow("multf", opFpRType, {5'd1, 5'd2, 5'd3, 6'd0, 5'h0e}, 12'b000000100100,
               2'b00, 4'h1);
        addRow("j", opJ, 26'h0000040, 12'b001000000000, 2'b00, 4'h2);
        addRow("jal", opJal, 26'h0000080, 12'b101000100000, 2'b00, 4'h3);
        addRow("jr", opJr, {5'd7, 21'd0}, 12'b011000000000, 2'b00, 4'h2);
        addRow("jalr", opJalr, {5'd8, 21'd0}, 12'b111000100000, 2'b00, 4'h3);
        addRow("beqz", opBeqz, {5'd1, 5'd0, 16'h0010}, 12'b000110000000, 2'b00, 4'h4);
        addRow("bnez", opBnez, {5'd2, 5'd0, 16'hfff0}, 12'b000100000000, 2'b00, 4'h5);
        addRow("addui", opAddui, {5'd1, 5'd2, 16'h1234}, 12'b000000100000, 2'b00, 4'h9);
        addRow("subui", opSubui, {5'd3, 5'd4, 16'h00ff}, 12'b000000100000, 2'b00, 4'hb);
        addRow("lhi", opLhi, {5'd0, 5'd5, 16'hbeef}, 12'b000000100001, 2'b00, 4'hf);
        addRow("lb", opLb, {5'd1, 5'd2, 16'h0004}, 12'b000000110000, 2'b00, 4'h0);
        addRow("lh", opLh, {5'd1, 5'd3, 16'h0008}, 12'b000000110000, 2'b01, 4'h1);
        addRow("lw", opLw, {5'd1, 5'd4, 16'h000c}, 12'b000000110000, 2'b11, 4'h3);
        addRow("lbu", opLbu, {5'd1, 5'd5, 16'h0010}, 12'b000000110000, 2'b00, 4'h4);
        addRow("lhu", opLhu, {5'd1, 5'd6, 16'h0014}, 12'b000000110000, 2'b01, 4'h5);
        addRow("sb", opSb, {5'd2, 5'd7, 16'h0020}, 12'b000000001000, 2'b00, 4'h8);
        addRow("sh", opSh, {5'd2, 5'd8, 16'h0024}, 12'b000000001000, 2'b01, 4'h9);
        addRow("sw", opSw, {5'd2, 5'd9, 16'h0028}, 12'b000000001000, 2'b11, 4'hb);

        repeat (8) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        readStatus(st);
        checkVal("reset empty", 1, st[0]);
        checkVal("reset count", 0, st[15:8]);

        // back-pressure, depth plus one words fit without waits
        for (int i = 0; i <= QueueDepth; i++) begin
            writeRow(i, waits);
            checkVal({rowName[i], " fill waits"}, 0, waits);
        end
        readStatus(st);
        checkVal("stalled count", QueueDepth, st[15:8]);
        checkVal("stalled full", 1, st[1]);
        fork
            writeRow(QueueDepth + 1, waits);
            begin
                repeat (5) @(negedge clk);
                readyMode <= 1;
            end
        join
        assert (waits >= 1)
        else stopRun($sformatf("FAILED stretched write expected waits>=1 actual %0d", waits));
        waitDrain();

        // unmapped address, nothing may reach the output
        apbXfer(1'b1, 8'h10, 32'hdead_beef, st, err, waits);
        checkVal("bad address pslverr", 1, err);
        repeat (4) @(negedge clk);
        checkVal("bad address ctrlValid", 0, ctrlValid);
        readStatus(st);
        checkVal("bad address empty", 1, st[0]);

        readyMode <= 2;
        for (int i = 0; i < rowInstr.size(); i++) begin
            writeRow(i, waits);
        end
        waitDrain();
        repeat (4) @(negedge clk);
        checkVal("final ctrlValid", 0, ctrlValid);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* dv/dlxDecodeProperties.sv */
module dlxDecodeProperties (
    input logic        clk,
    input logic        rstN,
    input logic        ctrlValid,
    input logic        ctrlReady,
    input logic [49:0] ctrlWord,
    input logic        pop,
    input logic        empty,
    input logic        psel,
    input logic        penable,
    input logic        pready,
    input logic        pslverr
);

    // a stalled output word must not move or drop
    holdWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
        ctrlValid && !ctrlReady |=> ctrlValid && $stable(ctrlWord))
        else $error("output word changed while stalled");

    noPopWhenEmpty: assert property (@(posedge clk) disable iff (!rstN)
        !(pop && empty))
        else $error("pop issued on an empty queue");

    // error response only in a completing access phase
    errOnlyInAccess: assert property (@(posedge clk) disable iff (!rstN)
        pslverr |-> (pready && psel && penable))
        else $error("pslverr outside a completing access phase");

endmodule

bind dlxDecodeTop dlxDecodeProperties props (
    .clk, .rstN, .ctrlValid, .ctrlReady,
    .ctrlWord({ctrlInstr, PCtoReg, regToPC, jump, branch, branchZero, RType, RegWrite,
               MemToReg, MemWrite, mul, extOp, LHIOp, DSize, ALUCtrl}),
    .pop, .empty, .psel, .penable, .pready, .pslverr
);

/* dv/tbClock.sv */
module tbClock #(
    parameter int Period = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(Period / 2) clk = ~clk;  // free running

endmodule

/* verilog/dlxDecodeTop.sv */
module dlxDecodeTop
    import dlxPkg::*;
#(
    parameter int QueueDepth = 4
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  instrT       pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        ctrlReady,
    output logic        ctrlValid,
    output instrT       ctrlInstr,
    output logic        PCtoReg,
    output logic        regToPC,
    output logic        jump,
    output logic        branch,
    output logic        branchZero,
    output logic        RType,
    output logic        RegWrite,
    output logic        MemToReg,
    output logic        MemWrite,
    output logic        mul,
    output logic        extOp,
    output logic        LHIOp,
    output logic [0:1]  DSize,
    output logic [0:3]  ALUCtrl
);

    localparam int CountW = $clog2(QueueDepth + 1);

    logic              push, pop, full, empty;
    logic [CountW-1:0] count;
    instrT             pushData, popData;

    instrApbPort #(.QueueDepth(QueueDepth), .CountW(CountW)) apbPort (
        .clk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .push, .pushData, .full, .count
    );

    instrQueue #(.payloadT(instrT), .QueueDepth(QueueDepth), .CountW(CountW)) queue (
        .clk, .rstN, .push, .pushData, .pop, .popData, .empty, .full, .count
    );

    decodeStage decode (
        .clk, .rstN, .pop, .popData, .empty, .ctrlValid, .ctrlReady,
        .PCtoReg, .regToPC, .jump, .branch, .branchZero, .RType, .RegWrite,
        .MemToReg, .MemWrite, .mul, .extOp, .LHIOp, .DSize, .ALUCtrl, .ctrlInstr
    );

endmodule

/* verilog/decodeStage.sv */
module decodeStage
    import dlxPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    output logic       pop,
    input  instrT      popData,
    input  logic       empty,
    output logic       ctrlValid,
    input  logic       ctrlReady,
    output logic       PCtoReg,
    output logic       regToPC,
    output logic       jump,
    output logic       branch,
    output logic       branchZero,
    output logic       RType,
    output logic       RegWrite,
    output logic       MemToReg,
    output logic       MemWrite,
    output logic       mul,
    output logic       extOp,
    output logic       LHIOp,
    output logic [0:1] DSize,
    output logic [0:3] ALUCtrl,
    output instrT      ctrlInstr
);

    logic       decPCtoReg, decRegToPC, decJump, decBranch, decBranchZero;
    logic       decRType, decRegWrite, decMemToReg, decMemWrite;
    logic       decMul, decExtOp, decLHIOp;
    logic [0:1] decDSize;
    logic [0:3] decALUCtrl;

    // decode straight off the queue head
    control ctrlDec (
        .instruction(popData),
        .PCtoReg(decPCtoReg), .regToPC(decRegToPC), .jump(decJump),
        .branch(decBranch), .branchZero(decBranchZero),
        .RType(decRType), .RegWrite(decRegWrite),
        .MemToReg(decMemToReg), .MemWrite(decMemWrite), .DSize(decDSize),
        .mul(decMul), .extOp(decExtOp), .LHIOp(decLHIOp), .ALUCtrl(decALUCtrl)
    );

    // reload when the slot is free or being taken this edge
    assign pop = !empty && (!ctrlValid || ctrlReady);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlValid <= 1'b0;
        end else if (pop) begin
            ctrlValid <= 1'b1;
        end else if (ctrlReady) begin
            ctrlValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            {PCtoReg, regToPC, jump, branch, branchZero} <=
                {decPCtoReg, decRegToPC, decJump, decBranch, decBranchZero};
            {RType, RegWrite, MemToReg, MemWrite} <=
                {decRType, decRegWrite, decMemToReg, decMemWrite};
            {mul, extOp, LHIOp} <= {decMul, decExtOp, decLHIOp};
            DSize     <= decDSize;
            ALUCtrl   <= decALUCtrl;
            ctrlInstr <= popData;  // kept for tracing
        end
    end

endmodule

/* verilog/control.sv */
module control
    import dlxPkg::*;
(
    input  instrT      instruction,
    // pc logic
    output logic       PCtoReg,     // jal, jalr
    output logic       regToPC,     // jr, jalr
    output logic       jump,
    output logic       branch,
    output logic       branchZero,  // beqz only
    // register file
    output logic       RType,
    output logic       RegWrite,
    // data memory
    output logic       MemToReg,    // loads
    output logic       MemWrite,    // stores
    output logic [0:1] DSize,
    // execute
    output logic       mul,
    output logic       extOp,       // low for addui and subui
    output logic       LHIOp,
    output logic [0:3] ALUCtrl
);

    logic [0:opcodeW-1] opcode;
    logic [0:funcW-1]   func;
    logic [0:4]         fpFunc;
    logic               fpRType;
    logic               jumpNotLink;

    assign opcode = instruction[0:opcodeW-1];
    assign func   = instruction[32-funcW:31];
    assign fpFunc = instruction[27:31];

    // j, jal, jr, jalr share 0x0_001x with bit 1 picking the register forms
    assign PCtoReg    = ~opcode[0] & ~opcode[2] & ~opcode[3] & opcode[4] & opcode[5];
    assign regToPC    = ~opcode[0] & opcode[1] & ~opcode[2] & ~opcode[3] & opcode[4];
    assign jump       = ~opcode[0] & ~opcode[2] & ~opcode[3] & opcode[4];
    assign branch     = ~opcode[0] & ~opcode[1] & ~opcode[2] & opcode[3] & ~opcode[4];
    assign branchZero = branch & ~opcode[5];
    assign jumpNotLink = jump & ~PCtoReg;

    assign RType   = (opcode == 6'b000000);  // opRType
    assign fpRType = (opcode == 6'b000001);  // opFpRType

    assign RegWrite = ~MemWrite & ~jumpNotLink & ~branch;
    assign MemToReg = opcode[0] & ~opcode[1] & ~opcode[2]
                    & (~opcode[4] | (~opcode[3] & opcode[4] & opcode[5]));
    assign MemWrite = opcode[0] & ~opcode[1] & opcode[2] & ~opcode[3]
                    & (~opcode[4] | (opcode[4] & opcode[5]));

    // fp mult family lives at fpfunc 0x0e and 0x16
    assign mul   = fpRType & fpFunc[2] & fpFunc[3] & ~fpFunc[4] & (fpFunc[0] ^ fpFunc[1]);
    assign extOp = opcode[0] & opcode[1] & ~opcode[2] & opcode[3] & ~opcode[5];
    assign LHIOp = (opcode == 6'b001111);  // opLhi

    // 00 byte, 01 half, 11 word
    assign DSize[0] = opcode[0] & ~opcode[1] & ~opcode[3] & opcode[4] & opcode[5];
    assign DSize[1] = (opcode[0] & ~opcode[1] & ~opcode[3] & opcode[5])
                    | (opcode[0] & ~opcode[1] & ~opcode[2] & opcode[3] & ~opcode[4] & opcode[5]);

    // r-type takes the low func bits, everything else the low opcode bits
    assign ALUCtrl = RType ? func[2:5] : opcode[2:5];

endmodule

/* verilog/instrQueue.sv */
module instrQueue #(
    parameter type payloadT   = logic [31:0],
    parameter int  QueueDepth = 4,
    parameter int  CountW     = $clog2(QueueDepth + 1)
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              push,
    input  payloadT           pushData,
    input  logic              pop,
    output payloadT           popData,
    output logic              empty,
    output logic              full,
    output logic [CountW-1:0] count
);

    localparam int PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;

    payloadT         mem [QueueDepth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic            doPush;
    logic            doPop;

    // wrap explicitly so any depth works, not only powers of two
    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        if (ptr == PtrW'(QueueDepth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign doPush = push && !full;
    assign doPop  = pop && !empty;

    assign empty   = (count == '0);
    assign full    = (count == CountW'(QueueDepth));
    assign popData = mem[rdPtr];  // fall-through, head always visible

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) wrPtr <= nextPtr(wrPtr);
            if (doPop) rdPtr <= nextPtr(rdPtr);
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

endmodule

/* verilog/instrApbPort.sv */
module instrApbPort
    import dlxPkg::*;
#(
    parameter int QueueDepth = 4,
    parameter int CountW     = $clog2(QueueDepth + 1)
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [7:0]        paddr,
    input  instrT             pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              push,
    output instrT             pushData,
    input  logic              full,
    input  logic [CountW-1:0] count
);

    logic access;
    logic instrWr;
    logic statusRd;
    logic badAddr;
    logic empty;

    assign access   = psel && penable;
    assign instrWr  = pwrite && (paddr == instrAddr);
    assign statusRd = !pwrite && (paddr == statusAddr);
    assign badAddr  = !(instrWr || statusRd);  // includes wrong direction

    // wait states only while an instruction write finds the queue full
    assign pready  = access && !(instrWr && full);
    assign pslverr = access && badAddr;

    // push lands on the completing edge, one per transfer
    assign push     = access && instrWr && !full;
    assign pushData = pwdata;

    assign empty = (count == '0);

    always_comb begin
        prdata       = '0;
        prdata[0]    = empty;
        prdata[1]    = full;
        prdata[15:8] = 8'(count);
    end

endmodule

/* verilog/dlxPkg.sv */
package dlxPkg;

    // instruction field widths, bit 0 is the msb as in the datapath
    localparam int opcodeW = 6;
    localparam int funcW   = 6;

    typedef logic [0:31] instrT;
    typedef logic [0:opcodeW-1] opcodeT;

    // apb address map
    localparam logic [7:0] instrAddr  = 8'h00;  // write only, pushes a word
    localparam logic [7:0] statusAddr = 8'h04;  // read only
    // status word: bit 0 empty, bit 1 full, bits 15:8 fill count

    // primary opcodes
    localparam opcodeT opRType   = 6'h00;  // integer r-type, func selects op
    localparam opcodeT opFpRType = 6'h01;  // fp r-type, only mul is decoded
    localparam opcodeT opJ       = 6'h02;
    localparam opcodeT opJal     = 6'h03;
    localparam opcodeT opBeqz    = 6'h04;
    localparam opcodeT opBnez    = 6'h05;
    localparam opcodeT opAddui   = 6'h09;
    localparam opcodeT opSubui   = 6'h0b;
    localparam opcodeT opLhi     = 6'h0f;
    localparam opcodeT opJr      = 6'h12;
    localparam opcodeT opJalr    = 6'h13;

    // loads
    localparam opcodeT opLb      = 6'h20;
    localparam opcodeT opLh      = 6'h21;
    localparam opcodeT opLw      = 6'h23;
    localparam opcodeT opLbu     = 6'h24;
    localparam opcodeT opLhu     = 6'h25;

    // stores
    localparam opcodeT opSb      = 6'h28;
    localparam opcodeT opSh      = 6'h29;
    localparam opcodeT opSw      = 6'h2b;

endpackage
